// ==== logic/rvIsaPkg.sv ====
`default_nettype none

package rvIsaPkg;

	typedef logic [31:0] wordT;
	typedef logic [31:0] addrT;
	typedef logic [31:0] instT;
	typedef logic [4:0] regIdxT;
	typedef logic [3:0] strbT;

	// major opcodes with low two bits always 2'b11 for 32-bit encodings
	localparam logic [6:0] opLui = 7'b0110111;
	localparam logic [6:0] opAuipc = 7'b0010111;
	localparam logic [6:0] opJal = 7'b1101111;
	localparam logic [6:0] opJalr = 7'b1100111;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opImm = 7'b0010011;
	localparam logic [6:0] opReg = 7'b0110011;
	localparam logic [6:0] opSystem = 7'b1110011;

	localparam logic [2:0] f3Beq = 3'b000;
	localparam logic [2:0] f3Bne = 3'b001;
	localparam logic [2:0] f3Blt = 3'b100;
	localparam logic [2:0] f3Bge = 3'b101;
	localparam logic [2:0] f3Bltu = 3'b110;
	localparam logic [2:0] f3Bgeu = 3'b111;

	localparam logic [2:0] f3Lb = 3'b000;
	localparam logic [2:0] f3Lh = 3'b001;
	localparam logic [2:0] f3Lw = 3'b010;
	localparam logic [2:0] f3Lbu = 3'b100;
	localparam logic [2:0] f3Lhu = 3'b101;

	localparam logic [2:0] f3Sb = 3'b000;
	localparam logic [2:0] f3Sh = 3'b001;
	localparam logic [2:0] f3Sw = 3'b010;

	localparam logic [2:0] f3Add = 3'b000; // also sub
	localparam logic [2:0] f3Sll = 3'b001;
	localparam logic [2:0] f3Slt = 3'b010;
	localparam logic [2:0] f3Sltu = 3'b011;
	localparam logic [2:0] f3Xor = 3'b100;
	localparam logic [2:0] f3Srl = 3'b101; // also sra
	localparam logic [2:0] f3Or = 3'b110;
	localparam logic [2:0] f3And = 3'b111;

	localparam logic [6:0] f7Base = 7'b0000000;
	localparam logic [6:0] f7Alt = 7'b0100000; // sub, sra, srai

	localparam instT ebreakInst = 32'h0010_0073;

endpackage

`default_nettype wire

// ==== logic/coreCtrlPkg.sv ====
`default_nettype none

package coreCtrlPkg;

	typedef logic [3:0] aluOpT;
	localparam aluOpT aluAdd = 4'd0;
	localparam aluOpT aluSub = 4'd1;
	localparam aluOpT aluSll = 4'd2;
	localparam aluOpT aluSlt = 4'd3;
	localparam aluOpT aluSltu = 4'd4;
	localparam aluOpT aluXor = 4'd5;
	localparam aluOpT aluSrl = 4'd6;
	localparam aluOpT aluSra = 4'd7;
	localparam aluOpT aluOr = 4'd8;
	localparam aluOpT aluAnd = 4'd9;
	localparam aluOpT aluPassB = 4'd10; // lui

	typedef logic [1:0] pcSelT;
	localparam pcSelT pcSelPlus4 = 2'd0;
	localparam pcSelT pcSelBranch = 2'd1;
	localparam pcSelT pcSelJreg = 2'd2;

	typedef logic [1:0] wbSelT;
	localparam wbSelT wbAlu = 2'd0;
	localparam wbSelT wbLoad = 2'd1;
	localparam wbSelT wbPc4 = 2'd2;
	localparam wbSelT wbPcImm = 2'd3;

	// same encoding as funct3[1:0] of loads and stores
	typedef logic [1:0] memSizeT;
	localparam memSizeT sizeByte = 2'd0;
	localparam memSizeT sizeHalf = 2'd1;
	localparam memSizeT sizeWord = 2'd2;

	typedef enum logic [1:0] {
		stRunning,
		stStopped,
		stTrapped
	} runStateT;

endpackage

`default_nettype wire

// ==== logic/fetchUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchUnit import rvIsaPkg::*, coreCtrlPkg::*; #(
	parameter addrT resetPc = 32'h8000_0000
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic isBranch,
	input wire logic branchTaken,
	input wire logic isJal,
	input wire logic isJalr,
	input wire logic illegal,
	input wire logic ebreak,
	input wire wordT imm,
	input wire addrT jumpReg,
	output addrT pc,
	output addrT pcPlus4,
	output addrT pcImm,
	output logic running,
	output logic halted,
	output logic trapped
);

	runStateT state;
	pcSelT pcSel;
	addrT nextPc;

	assign pcPlus4 = pc + 32'd4;
	assign pcImm = pc + imm; // branch, jal and auipc share this adder

	always_comb begin
		if (isJalr)
			pcSel = pcSelJreg;
		else if (isJal || (isBranch && branchTaken))
			pcSel = pcSelBranch;
		else
			pcSel = pcSelPlus4;
	end

	always_comb begin
		case (pcSel)
			pcSelPlus4: nextPc = pcPlus4;
			pcSelBranch: nextPc = pcImm;
			pcSelJreg: nextPc = {jumpReg[31:1], 1'b0};
			default: nextPc = pcPlus4;
		endcase
	end

	// halting instruction keeps its own pc
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= resetPc;
			state <= stRunning;
		end else if (state == stRunning) begin
			if (illegal)
				state <= stTrapped;
			else if (ebreak)
				state <= stStopped;
			else
				pc <= nextPc;
		end
	end

	assign running = (state == stRunning);
	assign halted = (state != stRunning);
	assign trapped = (state == stTrapped);

endmodule

`default_nettype wire

// ==== logic/instDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instDecoder import rvIsaPkg::*, coreCtrlPkg::*; (
	input wire instT inst,
	input wire logic running,
	output aluOpT aluOp,
	output logic aluSrcImm,
	output logic regWe,
	output logic memWrite,
	output logic memRead,
	output logic isBranch,
	output logic isJal,
	output logic isJalr,
	output wbSelT wbSel,
	output memSizeT memSize,
	output logic loadUnsigned,
	output logic [2:0] branchCond,
	output wordT imm,
	output regIdxT rs1,
	output regIdxT rs2,
	output regIdxT rd,
	output logic illegal,
	output logic ebreak
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	wordT immI;
	wordT immS;
	wordT immB;
	wordT immU;
	wordT immJ;
	aluOpT regOp;
	logic weRaw;
	logic storeRaw;
	logic legal;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rd = inst[11:7];
	assign rs1 = inst[19:15];
	assign rs2 = inst[24:20];

	assign immI = {{20{inst[31]}}, inst[31:20]};
	assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign immU = {inst[31:12], 12'b0};
	assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	assign branchCond = funct3;
	assign memSize = funct3[1:0];
	assign loadUnsigned = funct3[2];

	// op and op-imm share the funct3 map and bit 30 picks sub/sra
	always_comb begin
		case (funct3)
			f3Add: regOp = (opcode == opReg && funct7[5]) ? aluSub : aluAdd;
			f3Sll: regOp = aluSll;
			f3Slt: regOp = aluSlt;
			f3Sltu: regOp = aluSltu;
			f3Xor: regOp = aluXor;
			f3Srl: regOp = funct7[5] ? aluSra : aluSrl;
			f3Or: regOp = aluOr;
			f3And: regOp = aluAnd;
		endcase
	end

	always_comb begin
		aluOp = aluAdd;
		aluSrcImm = 1'b0;
		weRaw = 1'b0;
		storeRaw = 1'b0;
		memRead = 1'b0;
		isBranch = 1'b0;
		isJal = 1'b0;
		isJalr = 1'b0;
		wbSel = wbAlu;
		imm = immI;
		legal = 1'b0;
		case (opcode)
			opLui: begin
				legal = 1'b1;
				weRaw = 1'b1;
				aluOp = aluPassB;
				aluSrcImm = 1'b1;
				imm = immU;
			end
			opAuipc: begin
				legal = 1'b1;
				weRaw = 1'b1;
				wbSel = wbPcImm;
				imm = immU;
			end
			opJal: begin
				legal = 1'b1;
				weRaw = 1'b1;
				isJal = 1'b1;
				wbSel = wbPc4;
				imm = immJ;
			end
			opJalr: begin
				legal = (funct3 == 3'b000);
				weRaw = 1'b1;
				isJalr = 1'b1;
				aluSrcImm = 1'b1; // rs1 + imm
				wbSel = wbPc4;
			end
			opBranch: begin
				legal = funct3 inside {f3Beq, f3Bne, f3Blt, f3Bge, f3Bltu, f3Bgeu};
				isBranch = 1'b1;
				aluOp = aluSub;
				imm = immB;
			end
			opLoad: begin
				legal = funct3 inside {f3Lb, f3Lh, f3Lw, f3Lbu, f3Lhu};
				weRaw = 1'b1;
				memRead = 1'b1;
				aluSrcImm = 1'b1;
				wbSel = wbLoad;
			end
			opStore: begin
				legal = funct3 inside {f3Sb, f3Sh, f3Sw};
				storeRaw = 1'b1;
				aluSrcImm = 1'b1;
				imm = immS;
			end
			opImm: begin
				weRaw = 1'b1;
				aluSrcImm = 1'b1;
				aluOp = regOp;
				if (funct3 == f3Sll)
					legal = (funct7 == f7Base);
				else if (funct3 == f3Srl)
					legal = funct7 inside {f7Base, f7Alt};
				else
					legal = 1'b1;
			end
			opReg: begin
				weRaw = 1'b1;
				aluOp = regOp;
				legal = (funct7 == f7Base) || (funct7 == f7Alt && funct3 inside {f3Add, f3Srl});
			end
			opSystem: legal = (inst == ebreakInst); // ecall and csr ops trap
			default: legal = 1'b0;
		endcase
	end

	assign illegal = ~legal;
	assign ebreak = (inst == ebreakInst);
	assign regWe = weRaw & legal & running;
	assign memWrite = storeRaw & legal & running;

endmodule

`default_nettype wire

// ==== logic/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile import rvIsaPkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic we,
	input wire regIdxT waddr,
	input wire regIdxT raddr1,
	input wire regIdxT raddr2,
	input wire wordT wdata,
	output wordT rdata1,
	output wordT rdata2
);

	wordT regs [1:31]; // no storage behind x0

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (we && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu import rvIsaPkg::*, coreCtrlPkg::*; (
	input wire wordT a,
	input wire wordT b,
	input wire aluOpT op,
	input wire logic [2:0] branchCond,
	output wordT result,
	output logic branchTaken
);

	logic eq;
	logic lt;
	logic ltu;

	assign eq = (a == b);
	assign lt = ($signed(a) < $signed(b));
	assign ltu = (a < b);

	always_comb begin
		case (op)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluSll: result = a << b[4:0];
			aluSlt: result = {31'b0, lt};
			aluSltu: result = {31'b0, ltu};
			aluXor: result = a ^ b;
			aluSrl: result = a >> b[4:0];
			aluSra: result = $signed(a) >>> b[4:0];
			aluOr: result = a | b;
			aluAnd: result = a & b;
			aluPassB: result = b;
			default: result = a + b;
		endcase
	end

	// only meaningful when the decoder flags a branch
	always_comb begin
		case (branchCond)
			f3Beq: branchTaken = eq;
			f3Bne: branchTaken = ~eq;
			f3Blt: branchTaken = lt;
			f3Bge: branchTaken = ~lt;
			f3Bltu: branchTaken = ltu;
			f3Bgeu: branchTaken = ~ltu;
			default: branchTaken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/loadStoreUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit import rvIsaPkg::*, coreCtrlPkg::*; (
	input wire logic memWrite,
	input wire memSizeT memSize,
	input wire logic loadUnsigned,
	input wire logic [1:0] addrLow,
	input wire wordT storeData,
	input wire wordT memRdata,
	output wordT dmemWdata,
	output strbT dmemStrb,
	output logic dmemWe,
	output wordT loadData
);

	strbT laneMask;
	wordT laneWord;

	// store data copied into every lane so the strobe alone places it
	always_comb begin
		case (memSize)
			sizeByte: begin
				dmemWdata = {4{storeData[7:0]}};
				laneMask = 4'b0001 << addrLow;
			end
			sizeHalf: begin
				dmemWdata = {2{storeData[15:0]}};
				laneMask = addrLow[1] ? 4'b1100 : 4'b0011;
			end
			sizeWord: begin
				dmemWdata = storeData;
				laneMask = 4'b1111;
			end
			default: begin
				dmemWdata = storeData;
				laneMask = 4'b0000;
			end
		endcase
	end

	assign dmemStrb = memWrite ? laneMask : 4'b0000;
	assign dmemWe = memWrite;

	assign laneWord = memRdata >> {addrLow, 3'b000}; // addressed lane down to bit 0

	always_comb begin
		case (memSize)
			sizeByte: loadData = {{24{~loadUnsigned & laneWord[7]}}, laneWord[7:0]};
			sizeHalf: loadData = {{16{~loadUnsigned & laneWord[15]}}, laneWord[15:0]};
			sizeWord: loadData = memRdata;
			default: loadData = memRdata;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/rvCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvCore import rvIsaPkg::*, coreCtrlPkg::*; #(
	parameter addrT resetPc = 32'h8000_0000
) (
	input wire logic clk,
	input wire logic reset,
	output addrT imemAddr,
	input wire instT imemData,
	output addrT dmemAddr,
	input wire wordT dmemRdata,
	output wordT dmemWdata,
	output strbT dmemStrb,
	output logic dmemWe,
	output addrT pc,
	output logic halted,
	output logic illegal
);

	addrT pcPlus4;
	addrT pcImm;
	logic running;
	aluOpT aluOp;
	logic aluSrcImm;
	logic regWe;
	logic memWrite;
	logic memRead;
	logic isBranch;
	logic isJal;
	logic isJalr;
	wbSelT wbSel;
	memSizeT memSize;
	logic loadUnsigned;
	logic [2:0] branchCond;
	wordT imm;
	regIdxT rs1;
	regIdxT rs2;
	regIdxT rd;
	logic instIllegal;
	logic ebreak;
	wordT rs1Data;
	wordT rs2Data;
	wordT operandB;
	wordT aluResult;
	logic branchTaken;
	wordT loadData;
	wordT wbData;

	fetchUnit #(.resetPc(resetPc)) uFetch (
		.clk(clk), .reset(reset),
		.isBranch(isBranch), .branchTaken(branchTaken),
		.isJal(isJal), .isJalr(isJalr),
		.illegal(instIllegal), .ebreak(ebreak),
		.imm(imm), .jumpReg(aluResult),
		.pc(pc), .pcPlus4(pcPlus4), .pcImm(pcImm),
		.running(running), .halted(halted), .trapped(illegal)
	);

	instDecoder uDecode (
		.inst(imemData), .running(running),
		.aluOp(aluOp), .aluSrcImm(aluSrcImm), .regWe(regWe),
		.memWrite(memWrite), .memRead(memRead),
		.isBranch(isBranch), .isJal(isJal), .isJalr(isJalr),
		.wbSel(wbSel), .memSize(memSize), .loadUnsigned(loadUnsigned),
		.branchCond(branchCond), .imm(imm),
		.rs1(rs1), .rs2(rs2), .rd(rd),
		.illegal(instIllegal), .ebreak(ebreak)
	);

	regFile uRegs (
		.clk(clk), .reset(reset),
		.we(regWe), .waddr(rd), .raddr1(rs1), .raddr2(rs2),
		.wdata(wbData), .rdata1(rs1Data), .rdata2(rs2Data)
	);

	assign operandB = aluSrcImm ? imm : rs2Data;

	alu uAlu (
		.a(rs1Data), .b(operandB), .op(aluOp), .branchCond(branchCond),
		.result(aluResult), .branchTaken(branchTaken)
	);

	loadStoreUnit uLsu (
		.memWrite(memWrite), .memSize(memSize), .loadUnsigned(loadUnsigned),
		.addrLow(aluResult[1:0]), .storeData(rs2Data), .memRdata(dmemRdata),
		.dmemWdata(dmemWdata), .dmemStrb(dmemStrb), .dmemWe(dmemWe),
		.loadData(loadData)
	);

	assign imemAddr = pc;
	assign dmemAddr = (memRead || memWrite) ? aluResult : '0; // bus parked when idle

	always_comb begin
		case (wbSel)
			wbAlu: wbData = aluResult;
			wbLoad: wbData = loadData;
			wbPc4: wbData = pcPlus4; // link value
			wbPcImm: wbData = pcImm; // auipc
		endcase
	end

endmodule

`default_nettype wire

// ==== tb/rvCoreSva.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvCoreSva import rvIsaPkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic dmemWe,
	input wire strbT dmemStrb,
	input wire logic halted,
	input wire addrT pc
);

	noStoreWhenHalted: assert property (@(posedge clk) disable iff (reset)
		halted |-> !dmemWe)
		else $error("dmemWe high while halted");

	haltIsSticky: assert property (@(posedge clk) disable iff (reset)
		halted |=> halted)
		else $error("halted fell without reset");

	pcFrozen: assert property (@(posedge clk) disable iff (reset)
		halted |=> $stable(pc))
		else $error("pc moved while halted");

	strobeOnWrite: assert property (@(posedge clk) disable iff (reset)
		dmemWe |-> dmemStrb != 4'b0000)
		else $error("store with empty strobe");

endmodule

bind rvCore rvCoreSva uSva (.*);

`default_nettype wire

// ==== tb/rvCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvCoreTb import rvIsaPkg::*;;

	localparam addrT resetPc = 32'h8000_0000;
	localparam int progMax = 512; // instruction words
	localparam int dmemBytes = 512;
	localparam int dumpBase = 256; // x0..x15 dumped here with random data below
	localparam int bodyLen = 60;
	localparam int stepLimit = 2000;
	localparam int haltWait = 4;

	logic clk = 1'b0;
	logic reset;
	addrT imemAddr;
	instT imemData;
	addrT dmemAddr;
	wordT dmemRdata;
	wordT dmemWdata;
	strbT dmemStrb;
	logic dmemWe;
	addrT pc;
	logic halted;
	logic illegal;

	integer seed = 78918;
	instT prog [0:progMax-1];
	int progLen;
	logic [7:0] dmem [0:dmemBytes-1];
	logic [7:0] mMem [0:dmemBytes-1]; // reference copy
	wordT mReg [0:31];
	addrT mPc;
	logic mHalted;
	logic mIllegal;
	addrT imemIdx;
	addrT wordAddr;

	rvCore #(.resetPc(resetPc)) DUT (
		.clk(clk), .reset(reset),
		.imemAddr(imemAddr), .imemData(imemData),
		.dmemAddr(dmemAddr), .dmemRdata(dmemRdata), .dmemWdata(dmemWdata),
		.dmemStrb(dmemStrb), .dmemWe(dmemWe),
		.pc(pc), .halted(halted), .illegal(illegal)
	);

	always #20 clk = ~clk;

	assign imemIdx = (imemAddr - resetPc) >> 2;
	assign imemData = (imemIdx < progMax) ? prog[imemIdx] : '0;
	assign wordAddr = {dmemAddr[31:2], 2'b00};

	always_comb begin
		dmemRdata = '0;
		if (wordAddr < dmemBytes)
			for (int i = 0; i < 4; i++)
				dmemRdata[8*i +: 8] = dmem[wordAddr + i];
	end

	always @(posedge clk) begin
		if (!reset && dmemWe && wordAddr < dmemBytes)
			for (int i = 0; i < 4; i++)
				if (dmemStrb[i])
					dmem[wordAddr + i] <= dmemWdata[8*i +: 8];
	end

	task automatic failRun(string line);
		$display("%s", line);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic checkAddr(string what, addrT got, addrT exp);
		if (got !== exp)
			failRun($sformatf("ERROR at %0t: %s got %h, expected %h", $time, what, got, exp));
	endtask

	task automatic checkWord(string what, wordT got, wordT exp);
		if (got !== exp)
			failRun($sformatf("ERROR at %0t: %s got %h, expected %h", $time, what, got, exp));
	endtask

	task automatic checkStrb(string what, strbT got, strbT exp);
		if (got !== exp)
			failRun($sformatf("ERROR at %0t: %s got %b, expected %b", $time, what, got, exp));
	endtask

	task automatic checkFlag(string what, logic got, logic exp);
		if (got !== exp)
			failRun($sformatf("ERROR at %0t: %s got %b, expected %b", $time, what, got, exp));
	endtask

	function automatic int unsigned rnd(int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic wordT rndWord();
		return $random(seed);
	endfunction

	function automatic regIdxT randRd();
		return regIdxT'(1 + rnd(15));
	endfunction

	function automatic regIdxT randRs();
		return regIdxT'(rnd(16));
	endfunction

	function automatic instT encR(logic [6:0] f7, regIdxT rs2, regIdxT rs1, logic [2:0] f3,
			regIdxT rd, logic [6:0] op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	function automatic instT encI(logic [11:0] imm, regIdxT rs1, logic [2:0] f3, regIdxT rd,
			logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic instT encS(logic [11:0] imm, regIdxT rs2, regIdxT rs1, logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
	endfunction

	function automatic instT encB(logic [12:0] imm, regIdxT rs2, regIdxT rs1, logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
	endfunction

	function automatic instT encJ(logic [20:0] imm, regIdxT rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
	endfunction

	task automatic emit(instT in);
		prog[progLen] = in;
		progLen++;
	endtask

	task automatic emitAlu();
		logic [2:0] f3;
		logic alt;
		wordT r;
		f3 = 3'(rnd(8));
		alt = 1'(rnd(2));
		r = rndWord();
		case (rnd(4))
			0: emit({r[31:12], randRd(), opLui});
			1: emit({r[31:12], randRd(), opAuipc});
			2: begin
				if (f3 == f3Sll)
					emit(encI({7'b0, r[4:0]}, randRs(), f3, randRd(), opImm));
				else if (f3 == f3Srl)
					emit(encI({1'b0, alt, 5'b0, r[4:0]}, randRs(), f3, randRd(), opImm));
				else
					emit(encI(r[11:0], randRs(), f3, randRd(), opImm));
			end
			default: emit(encR((alt && (f3 == f3Add || f3 == f3Srl)) ? f7Alt : f7Base,
				randRs(), randRs(), f3, randRd(), opReg));
		endcase
	endtask

	// every jump lands on the first word after its skipped fillers
	task automatic emitFlow();
		int skip;
		logic [2:0] f3;
		regIdxT rr;
		skip = 1 + rnd(3);
		f3 = 3'(rnd(6));
		if (f3 > 3'd1)
			f3 = f3 + 3'd2; // 0,1,4,5,6,7
		case (rnd(3))
			0: emit(encB(13'(4 * (skip + 1)), randRs(), randRs(), f3));
			1: emit(encJ(21'(4 * (skip + 1)), randRs()));
			default: begin
				rr = randRd();
				emit({20'h0, rr, opAuipc});
				emit(encI(12'(12 + rnd(2)), rr, 3'b000, randRs(), opJalr)); // odd target too
				skip = 1;
			end
		endcase
		repeat (skip) emitAlu();
	endtask

	task automatic emitMem();
		logic [2:0] f3;
		logic [7:0] a;
		a = 8'(rnd(256));
		if (rnd(2)) begin
			f3 = 3'(rnd(3));
			a = a & ~((8'd1 << f3[1:0]) - 8'd1); // natural alignment
			emit(encS({4'b0, a}, randRs(), 5'd0, f3));
		end else begin
			f3 = 3'(rnd(5));
			if (f3 > 3'd2)
				f3 = f3 + 3'd1;
			a = a & ~((8'd1 << f3[1:0]) - 8'd1);
			emit(encI({4'b0, a}, 5'd0, f3, randRd(), opLoad));
		end
	endtask

	task automatic genProgram(bit withIllegal);
		int badAt;
		wordT r;
		progLen = 0;
		for (int i = 0; i < progMax; i++)
			prog[i] = '0;
		badAt = withIllegal ? int'(rnd(bodyLen)) : -1;
		for (int i = 1; i < 16; i++) begin
			r = rndWord();
			emit({r[31:12], regIdxT'(i), opLui});
			emit(encI(r[11:0], regIdxT'(i), f3Add, regIdxT'(i), opImm));
		end
		for (int j = 0; j < bodyLen; j++) begin
			if (j == badAt) begin
				r = rndWord();
				if (rnd(2))
					emit({r[31:7], 7'b0001011}); // custom-0 opcode
				else
					emit(encR(7'b0000001, r[24:20], r[19:15], r[14:12], r[11:7], opReg));
			end
			case (rnd(3))
				0: emitAlu();
				1: emitFlow();
				default: emitMem();
			endcase
		end
		for (int i = 0; i < 16; i++)
			emit(encS(12'(dumpBase + 4 * i), regIdxT'(i), 5'd0, f3Sw));
		emit(ebreakInst);
	endtask

	task automatic initMemory();
		logic [7:0] b;
		for (int i = 0; i < dmemBytes; i++) begin
			b = 8'($random(seed));
			dmem[i] = b;
			mMem[i] = b;
		end
	endtask

	function automatic bit isLegal(instT in);
		logic [2:0] f3;
		logic [6:0] f7;
		f3 = in[14:12];
		f7 = in[31:25];
		case (in[6:0])
			opLui, opAuipc, opJal: return 1'b1;
			opJalr: return f3 == 3'b000;
			opBranch: return f3 != 3'b010 && f3 != 3'b011;
			opLoad: return f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
			opStore: return f3 < 3'b011;
			opImm: begin
				if (f3 == f3Sll)
					return f7 == f7Base;
				if (f3 == f3Srl)
					return f7 == f7Base || f7 == f7Alt;
				return 1'b1;
			end
			opReg: return f7 == f7Base || (f7 == f7Alt && (f3 == f3Add || f3 == f3Srl));
			opSystem: return in == ebreakInst;
			default: return 1'b0;
		endcase
	endfunction

	function automatic wordT aluValue(logic [2:0] f3, logic alt, wordT a, wordT b);
		case (f3)
			f3Add: return alt ? a - b : a + b;
			f3Sll: return a << b[4:0];
			f3Slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			f3Sltu: return (a < b) ? 32'd1 : 32'd0;
			f3Xor: return a ^ b;
			f3Srl: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			f3Or: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic bit branchTaken(logic [2:0] f3, wordT a, wordT b);
		case (f3)
			f3Beq: return a == b;
			f3Bne: return a != b;
			f3Blt: return $signed(a) < $signed(b);
			f3Bge: return $signed(a) >= $signed(b);
			f3Bltu: return a < b;
			default: return a >= b;
		endcase
	endfunction

	// little-endian bytes out of the reference memory
	function automatic wordT loadValue(logic [2:0] f3, addrT ea);
		case (f3)
			f3Lb: return {{24{mMem[ea][7]}}, mMem[ea]};
			f3Lh: return {{16{mMem[ea + 1][7]}}, mMem[ea + 1], mMem[ea]};
			f3Lw: return {mMem[ea + 3], mMem[ea + 2], mMem[ea + 1], mMem[ea]};
			f3Lbu: return {24'b0, mMem[ea]};
			default: return {16'b0, mMem[ea + 1], mMem[ea]};
		endcase
	endfunction

	task automatic storeValue(logic [2:0] f3, addrT ea, wordT b);
		int n;
		strbT strb;
		wordT expData;
		wordT laneMask;
		n = 1 << f3[1:0];
		strb = '0;
		expData = '0;
		laneMask = '0;
		for (int i = 0; i < n; i++) begin
			strb[ea[1:0] + i] = 1'b1;
			expData[8*(ea[1:0] + i) +: 8] = b[8*i +: 8];
			laneMask[8*(ea[1:0] + i) +: 8] = 8'hff;
			mMem[ea + i] = b[8*i +: 8];
		end
		checkAddr("store address", dmemAddr, ea);
		checkStrb("store strobe", dmemStrb, strb);
		checkWord("store data", dmemWdata & laneMask, expData); // unused lanes are don't care
	endtask

	task automatic setReg(regIdxT rd, wordT v);
		if (rd != 5'd0)
			mReg[rd] = v;
	endtask

	// one instruction of the reference compared against the DUT mid-cycle
	task automatic modelStep();
		instT in;
		addrT idx;
		regIdxT rd;
		logic [2:0] f3;
		wordT a;
		wordT b;
		wordT immI;
		wordT immS;
		wordT immB;
		wordT immJ;
		wordT immU;
		addrT nextPc;
		idx = (mPc - resetPc) >> 2;
		in = (idx < progMax) ? prog[idx] : '0;
		rd = in[11:7];
		f3 = in[14:12];
		a = mReg[in[19:15]];
		b = mReg[in[24:20]];
		immI = {{20{in[31]}}, in[31:20]};
		immS = {{20{in[31]}}, in[31:25], in[11:7]};
		immB = {{20{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
		immJ = {{12{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
		immU = {in[31:12], 12'b0};
		nextPc = mPc + 32'd4;
		checkAddr("pc", pc, mPc);
		checkAddr("imemAddr", imemAddr, mPc);
		checkFlag("halted", halted, 1'b0);
		checkFlag("dmemWe", dmemWe, in[6:0] == opStore && isLegal(in));
		if (!isLegal(in) || in == ebreakInst) begin
			mHalted = 1'b1;
			mIllegal = !isLegal(in);
		end else begin
			case (in[6:0])
				opLui: setReg(rd, immU);
				opAuipc: setReg(rd, mPc + immU);
				opJal: begin
					setReg(rd, mPc + 32'd4);
					nextPc = mPc + immJ;
				end
				opJalr: begin
					nextPc = (a + immI) & ~32'd1;
					setReg(rd, mPc + 32'd4);
				end
				opBranch: begin
					if (branchTaken(f3, a, b))
						nextPc = mPc + immB;
				end
				opLoad: begin
					checkAddr("load address", dmemAddr, a + immI);
					setReg(rd, loadValue(f3, a + immI));
				end
				opStore: storeValue(f3, a + immS, b);
				opImm: setReg(rd, aluValue(f3, in[30] && f3 == f3Srl, a, immI));
				default: setReg(rd, aluValue(f3, in[30], a, b));
			endcase
			mPc = nextPc;
		end
	endtask

	task automatic runProgram(bit withIllegal);
		int cycles;
		genProgram(withIllegal);
		initMemory();
		for (int i = 0; i < 32; i++)
			mReg[i] = '0;
		mPc = resetPc;
		mHalted = 1'b0;
		mIllegal = 1'b0;
		@(posedge clk);
		#1 reset = 1'b1;
		repeat (10) @(posedge clk);
		#1 reset = 1'b0;
		@(negedge clk);
		checkAddr("pc after reset", pc, resetPc);
		checkFlag("halted after reset", halted, 1'b0);
		checkFlag("illegal after reset", illegal, 1'b0);
		checkFlag("dmemWe after reset", dmemWe, 1'b0);
		cycles = 0;
		while (!mHalted) begin
			modelStep();
			cycles++;
			if (cycles > stepLimit)
				failRun($sformatf("Timeout at %0t: program never reached its halt", $time));
			@(negedge clk);
		end
		cycles = 0;
		while (halted !== 1'b1) begin
			cycles++;
			if (cycles > haltWait)
				failRun($sformatf("Timeout at %0t: halted did not rise after the halt", $time));
			@(negedge clk);
		end
		repeat (4) begin // frozen state with no stores
			checkFlag("illegal", illegal, mIllegal);
			checkFlag("dmemWe after halt", dmemWe, 1'b0);
			checkAddr("pc after halt", pc, mPc);
			@(negedge clk);
		end
	endtask

	initial begin
		reset = 1'b1;
		runProgram(1'b0); // ends in ebreak
		runProgram(1'b1); // traps mid-stream
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
logic/rvIsaPkg.sv
logic/coreCtrlPkg.sv
logic/fetchUnit.sv
logic/instDecoder.sv
logic/regFile.sv
logic/alu.sv
logic/loadStoreUnit.sv
logic/rvCore.sv
tb/rvCoreSva.sv
tb/rvCoreTb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - logic/rvIsaPkg.sv
  - logic/coreCtrlPkg.sv
  - logic/fetchUnit.sv
  - logic/instDecoder.sv
  - logic/regFile.sv
  - logic/alu.sv
  - logic/loadStoreUnit.sv
  - logic/rvCore.sv
  - target: simulation
    files:
      - tb/rvCoreSva.sv
      - tb/rvCoreTb.sv
